// File: hdl/fe_rx_cfg.svh
// widths, depth and code constants of the front-end receiver, included by the RTL files
`ifndef FE_RX_CFG_SVH
`define FE_RX_CFG_SVH

`define FE_RX_VERSION       8'd2
`define FE_RX_FIFO_DEPTH    8         // small so overflow is easy to reach
`define FE_RX_SIZE_W        16
`define FE_RX_SYNC_COMMAS   4

// symbol and payload widths
`define FE_RX_SYM_W         10
`define FE_RX_DATA_W        24
`define FE_RX_DATA_ID       8'hA5     // header byte over every fifo word

// control characters as decoded bytes
`define FE_RX_K_SOF         8'hFC     // K28.7
`define FE_RX_K_EOF         8'h7C     // K28.3
`define FE_RX_K_COMMA       8'hBC     // K28.5

// K28.5 on the line, abcdei fghj with a first
`define FE_RX_COMMA_RDN     10'h0FA
`define FE_RX_COMMA_RDP     10'h305

`endif

// File: hdl/fe_rx_pkg.sv
// types passed between the receive chain blocks, referenced by scoped name
`include "fe_rx_cfg.svh"

package fe_rx_pkg;

    // one line symbol, a is the msb and the first bit on the wire
    typedef struct packed {
        logic [`FE_RX_SYM_W-1:0] code;
        logic                    valid;
    } rx_symbol_t;

    // same eight bits, read as a value or as a K-code
    typedef union packed {
        logic [7:0] data;         // HGFEDCBA
        struct packed {
            logic [2:0] y;        // K x.y
            logic [4:0] x;
        } ctrl;
    } rx_byte_u;

    typedef struct packed {
        rx_byte_u value;
        logic     is_k;
        logic     code_err;       // sub-block not in the tables
        logic     valid;
    } rx_byte_t;

    typedef struct packed {
        logic [7:0]               header;
        logic [`FE_RX_DATA_W-1:0] data;
    } fifo_word_t;

endpackage

// File: hdl/rx_symbol_align.sv
// serial front end, locks onto K28.5 commas and hands aligned 10-bit symbols to the decoder
`timescale 1ns/100ps
`include "fe_rx_cfg.svh"

module rx_symbol_align (
    input  wire                   BUS_CLK,
    input  wire                   rst,
    input  wire                   rx_data,
    input  wire                   bit_en,
    input  wire                   invert,
    output fe_rx_pkg::rx_symbol_t symbol,
    output logic                  ready
);

    localparam int SYM_W = `FE_RX_SYM_W;

    logic [SYM_W-1:0] window;
    logic [SYM_W-1:0] window_next;
    logic [3:0]       bit_cnt;        // position inside the current symbol
    logic [3:0]       comma_cnt;      // aligned commas in a row
    logic             is_comma;
    logic             at_boundary;

    assign window_next = {window[SYM_W-2:0], rx_data ^ invert};
    assign is_comma    = (window_next == `FE_RX_COMMA_RDN) ||
                         (window_next == `FE_RX_COMMA_RDP);
    assign at_boundary = (bit_cnt == 4'(SYM_W - 1));

    always_ff @(posedge BUS_CLK) begin
        if (rst) begin
            window       <= '0;
            bit_cnt      <= '0;
            comma_cnt    <= '0;
            ready        <= 1'b0;
            symbol.valid <= 1'b0;
        end else begin
            symbol.valid <= 1'b0;
            if (bit_en) begin
                window <= window_next;
                if (!ready && is_comma) begin
                    bit_cnt <= '0;    // comma sets the boundary until locked
                    if (at_boundary) begin
                        comma_cnt <= comma_cnt + 4'd1;
                        if (comma_cnt == 4'(`FE_RX_SYNC_COMMAS - 1))
                            ready <= 1'b1;
                    end else begin
                        comma_cnt <= 4'd1;  // new alignment, first comma of the run
                    end
                end else begin
                    bit_cnt <= at_boundary ? '0 : bit_cnt + 4'd1;
                    if (at_boundary) begin
                        if (ready) begin
                            symbol.code  <= window_next;
                            symbol.valid <= 1'b1;
                        end else begin
                            comma_cnt <= '0;    // run broken by another symbol
                        end
                    end
                end
            end
        end
    end

endmodule

// File: hdl/dec_8b10b.sv
// 8b10b table decoder, both disparity forms accepted, K28.x and Kx.7 flagged as control
`timescale 1ns/100ps

module dec_8b10b (
    input  wire                   BUS_CLK,
    input  wire                   rst,
    input  fe_rx_pkg::rx_symbol_t symbol,
    output fe_rx_pkg::rx_byte_t   rx_byte
);

    // abcdei to {err, EDCBA}
    function automatic logic [5:0] dec6(input logic [5:0] sb);
        case (sb)
            6'b100111, 6'b011000: dec6 = {1'b0, 5'd0};
            6'b011101, 6'b100010: dec6 = {1'b0, 5'd1};
            6'b101101, 6'b010010: dec6 = {1'b0, 5'd2};
            6'b110001:            dec6 = {1'b0, 5'd3};
            6'b110101, 6'b001010: dec6 = {1'b0, 5'd4};
            6'b101001:            dec6 = {1'b0, 5'd5};
            6'b011001:            dec6 = {1'b0, 5'd6};
            6'b111000, 6'b000111: dec6 = {1'b0, 5'd7};
            6'b111001, 6'b000110: dec6 = {1'b0, 5'd8};
            6'b100101:            dec6 = {1'b0, 5'd9};
            6'b010101:            dec6 = {1'b0, 5'd10};
            6'b110100:            dec6 = {1'b0, 5'd11};
            6'b001101:            dec6 = {1'b0, 5'd12};
            6'b101100:            dec6 = {1'b0, 5'd13};
            6'b011100:            dec6 = {1'b0, 5'd14};
            6'b010111, 6'b101000: dec6 = {1'b0, 5'd15};
            6'b011011, 6'b100100: dec6 = {1'b0, 5'd16};
            6'b100011:            dec6 = {1'b0, 5'd17};
            6'b010011:            dec6 = {1'b0, 5'd18};
            6'b110010:            dec6 = {1'b0, 5'd19};
            6'b001011:            dec6 = {1'b0, 5'd20};
            6'b101010:            dec6 = {1'b0, 5'd21};
            6'b011010:            dec6 = {1'b0, 5'd22};
            6'b111010, 6'b000101: dec6 = {1'b0, 5'd23};
            6'b110011, 6'b001100: dec6 = {1'b0, 5'd24};
            6'b100110:            dec6 = {1'b0, 5'd25};
            6'b010110:            dec6 = {1'b0, 5'd26};
            6'b110110, 6'b001001: dec6 = {1'b0, 5'd27};
            6'b001110:            dec6 = {1'b0, 5'd28};
            6'b101110, 6'b010001: dec6 = {1'b0, 5'd29};
            6'b011110, 6'b100001: dec6 = {1'b0, 5'd30};
            6'b101011, 6'b010100: dec6 = {1'b0, 5'd31};
            default:              dec6 = {1'b1, 5'd0};
        endcase
    endfunction

    // fghj to {err, HGF} for data, P7 and A7 both give 7
    function automatic logic [3:0] dec4(input logic [3:0] sb);
        case (sb)
            4'b1011, 4'b0100:                   dec4 = {1'b0, 3'd0};
            4'b1001:                            dec4 = {1'b0, 3'd1};
            4'b0101:                            dec4 = {1'b0, 3'd2};
            4'b1100, 4'b0011:                   dec4 = {1'b0, 3'd3};
            4'b1101, 4'b0010:                   dec4 = {1'b0, 3'd4};
            4'b1010:                            dec4 = {1'b0, 3'd5};
            4'b0110:                            dec4 = {1'b0, 3'd6};
            4'b1110, 4'b0001, 4'b0111, 4'b1000: dec4 = {1'b0, 3'd7};
            default:                            dec4 = {1'b1, 3'd0};
        endcase
    endfunction

    // K28 tail in the form that follows 001111
    function automatic logic [3:0] dec4k(input logic [3:0] sb);
        case (sb)
            4'b0100: dec4k = {1'b0, 3'd0};
            4'b1001: dec4k = {1'b0, 3'd1};
            4'b0101: dec4k = {1'b0, 3'd2};
            4'b0011: dec4k = {1'b0, 3'd3};
            4'b0010: dec4k = {1'b0, 3'd4};
            4'b1010: dec4k = {1'b0, 3'd5};
            4'b0110: dec4k = {1'b0, 3'd6};
            4'b1000: dec4k = {1'b0, 3'd7};
            default: dec4k = {1'b1, 3'd0};
        endcase
    endfunction

    logic [5:0] sb6;
    logic [3:0] sb4;
    logic [5:0] r6;
    logic [3:0] r4;
    logic [3:0] rk;
    logic       is_k28;
    logic       is_kx7;

    assign sb6    = symbol.code[9:4];
    assign sb4    = symbol.code[3:0];
    assign r6     = dec6(sb6);
    assign r4     = dec4(sb4);
    assign rk     = dec4k(sb6[0] ? sb4 : ~sb4);   // 110000 flips the tail
    assign is_k28 = (sb6 == 6'b001111) || (sb6 == 6'b110000);
    // A7 tail behind 23, 27, 29 or 30 only occurs as a K-code
    assign is_kx7 = !r6[5] && (sb4 == 4'b0111 || sb4 == 4'b1000) &&
                    (r6[4:0] == 5'd23 || r6[4:0] == 5'd27 ||
                     r6[4:0] == 5'd29 || r6[4:0] == 5'd30);

    always_ff @(posedge BUS_CLK) begin
        if (rst) begin
            rx_byte.valid <= 1'b0;
        end else begin
            rx_byte.valid <= symbol.valid;
            if (symbol.valid) begin
                if (is_k28) begin
                    rx_byte.value.ctrl.x <= 5'd28;
                    rx_byte.value.ctrl.y <= rk[2:0];
                    rx_byte.is_k         <= 1'b1;
                    rx_byte.code_err     <= rk[3];
                end else if (is_kx7) begin
                    rx_byte.value.ctrl.x <= r6[4:0];
                    rx_byte.value.ctrl.y <= 3'd7;
                    rx_byte.is_k         <= 1'b1;
                    rx_byte.code_err     <= 1'b0;
                end else begin
                    rx_byte.value.data <= {r4[2:0], r6[4:0]};
                    rx_byte.is_k       <= 1'b0;
                    rx_byte.code_err   <= r6[5] | r4[3];
                end
            end
        end
    end

endmodule

// File: hdl/frame_packer.sv
// groups frame data bytes into 24-bit words for the fifo and counts decode and overflow errors
`timescale 1ns/100ps
`include "fe_rx_cfg.svh"

module frame_packer (
    input  wire                   BUS_CLK,
    input  wire                   rst,
    input  fe_rx_pkg::rx_byte_t   rx_byte,
    input  wire                   fifo_full,
    output logic                  push,
    output fe_rx_pkg::fifo_word_t word,
    output logic [7:0]            dec_err_cnt,
    output logic [7:0]            lost_cnt
);

    logic        in_frame;
    logic [1:0]  byte_idx;
    logic [15:0] acc;       // first two bytes, msb first
    logic [7:0]  rx_val;

    assign rx_val = rx_byte.value.data;

    always_ff @(posedge BUS_CLK) begin
        if (rst) begin
            in_frame    <= 1'b0;
            byte_idx    <= '0;
            push        <= 1'b0;
            dec_err_cnt <= '0;
            lost_cnt    <= '0;
        end else begin
            push <= 1'b0;
            if (rx_byte.valid) begin
                if (rx_byte.code_err) begin
                    if (dec_err_cnt != 8'hFF)
                        dec_err_cnt <= dec_err_cnt + 8'd1;
                    byte_idx <= '0;                     // word in progress is broken
                end else if (rx_byte.is_k) begin
                    if (rx_val == `FE_RX_K_SOF) begin
                        in_frame <= 1'b1;
                        byte_idx <= '0;
                    end else if (rx_val == `FE_RX_K_EOF) begin
                        in_frame <= 1'b0;
                        byte_idx <= '0;                 // partial word discarded
                    end else if (rx_val != `FE_RX_K_COMMA) begin
                        byte_idx <= '0;
                    end
                end else if (in_frame) begin
                    if (byte_idx == 2'd2) begin
                        byte_idx    <= '0;
                        word.header <= `FE_RX_DATA_ID;
                        word.data   <= {acc, rx_val};
                        if (!fifo_full)
                            push <= 1'b1;
                        else if (lost_cnt != 8'hFF)
                            lost_cnt <= lost_cnt + 8'd1;
                    end else begin
                        acc      <= {acc[7:0], rx_val};
                        byte_idx <= byte_idx + 2'd1;
                    end
                end
            end
        end
    end

endmodule

// File: hdl/word_fifo.sv
// first-word-fall-through fifo for receiver words, head word shown while not empty
`timescale 1ns/100ps
`include "fe_rx_cfg.svh"

module word_fifo (
    input  wire                      BUS_CLK,
    input  wire                      rst,
    input  wire                      push,
    input  fe_rx_pkg::fifo_word_t    din,
    input  wire                      pop,
    output fe_rx_pkg::fifo_word_t    dout,
    output wire                      empty,
    output wire                      full,
    output logic [`FE_RX_SIZE_W-1:0] count
);

    localparam int DEPTH  = `FE_RX_FIFO_DEPTH;
    localparam int AW     = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int SIZE_W = `FE_RX_SIZE_W;

    fe_rx_pkg::fifo_word_t mem [DEPTH];
    logic [AW-1:0]         wr_ptr;
    logic [AW-1:0]         rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign full    = (count == SIZE_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;     // push on full is dropped
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr];

    always_ff @(posedge BUS_CLK) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge BUS_CLK) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/fe_rx_core.sv
// receiver top, byte-wide register bus plus the align, decode, pack and fifo chain
`timescale 1ns/100ps
`include "fe_rx_cfg.svh"

module fe_rx_core (
    input  wire                   BUS_CLK,
    input  wire                   RST,
    input  wire                   rx_data,
    input  wire                   rx_bit_en,
    input  wire                   fifo_read,
    input  wire  [15:0]           bus_add,
    input  wire  [7:0]            bus_data_in,
    input  wire                   bus_wr,
    input  wire                   bus_rd,
    output logic [7:0]            bus_data_out,
    output wire                   rx_ready,
    output wire                   rx_dec_err,
    output wire                   rx_overflow_err,
    output wire                   fifo_empty,
    output wire                   fifo_full,
    output fe_rx_pkg::fifo_word_t fifo_data
);

    logic                     soft_rst_q;   // write to address 0, one cycle late
    logic                     rx_rst_q;     // write to address 1
    logic                     rx_rst;
    logic [7:1]               status_reg;   // bit 0 reads back ready
    logic [`FE_RX_SIZE_W-1:0] fifo_size;
    logic [7:0]               fifo_size_hi;
    logic [7:0]               dec_err_cnt;
    logic [7:0]               dec_err_copy;
    logic [7:0]               lost_cnt;
    logic [7:0]               lost_copy;
    logic                     push;
    fe_rx_pkg::rx_symbol_t    symbol;
    fe_rx_pkg::rx_byte_t      rx_byte;
    fe_rx_pkg::fifo_word_t    packed_word;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            soft_rst_q <= 1'b0;
            rx_rst_q   <= 1'b0;
        end else begin
            soft_rst_q <= bus_wr && (bus_add == 16'd0);
            rx_rst_q   <= bus_wr && (bus_add == 16'd1);
        end
    end

    assign rx_rst = RST | soft_rst_q | rx_rst_q;

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst_q)
            status_reg <= '0;
        else if (bus_wr && bus_add == 16'd2)
            status_reg <= bus_data_in[7:1];
    end

    // high byte frozen when the low byte is read
    always_ff @(posedge BUS_CLK) begin
        if (rx_rst)
            fifo_size_hi <= '0;
        else if (bus_rd && bus_add == 16'd3)
            fifo_size_hi <= fifo_size[15:8];
    end

    always_ff @(posedge BUS_CLK) begin
        dec_err_copy <= dec_err_cnt;
        lost_copy    <= lost_cnt;
    end

    always_ff @(posedge BUS_CLK) begin
        case (bus_add)
            16'd0:   bus_data_out <= `FE_RX_VERSION;
            16'd2:   bus_data_out <= {status_reg, rx_ready};
            16'd3:   bus_data_out <= fifo_size[7:0];
            16'd4:   bus_data_out <= fifo_size_hi;
            16'd5:   bus_data_out <= dec_err_copy;
            16'd6:   bus_data_out <= lost_copy;
            default: bus_data_out <= 8'd0;
        endcase
    end

    assign rx_dec_err      = (dec_err_cnt != 8'd0);
    assign rx_overflow_err = (lost_cnt != 8'd0);

    rx_symbol_align u_align (
        .BUS_CLK (BUS_CLK),
        .rst     (rx_rst),
        .rx_data (rx_data),
        .bit_en  (rx_bit_en),
        .invert  (status_reg[1]),
        .symbol  (symbol),
        .ready   (rx_ready)
    );

    dec_8b10b u_dec (
        .BUS_CLK (BUS_CLK),
        .rst     (rx_rst),
        .symbol  (symbol),
        .rx_byte (rx_byte)
    );

    frame_packer u_pack (
        .BUS_CLK     (BUS_CLK),
        .rst         (rx_rst),
        .rx_byte     (rx_byte),
        .fifo_full   (fifo_full),
        .push        (push),
        .word        (packed_word),
        .dec_err_cnt (dec_err_cnt),
        .lost_cnt    (lost_cnt)
    );

    word_fifo u_fifo (
        .BUS_CLK (BUS_CLK),
        .rst     (rx_rst),
        .push    (push),
        .din     (packed_word),
        .pop     (fifo_read),
        .dout    (fifo_data),
        .empty   (fifo_empty),
        .full    (fifo_full),
        .count   (fifo_size)
    );

endmodule

// File: tests/tb_fe_rx_core.sv
// table-driven testbench for fe_rx_core, serializes 8b10b symbols and checks registers and fifo words
`timescale 1ns/100ps
`include "fe_rx_cfg.svh"

module tb_fe_rx_core;

    localparam logic [2:0] K_WR  = 3'd0;
    localparam logic [2:0] K_RD  = 3'd1;
    localparam logic [2:0] K_SYM = 3'd2;
    localparam logic [2:0] K_POP = 3'd3;
    localparam logic [2:0] K_FLG = 3'd4;

    // RD- column codes, abcdei fghj, a sent first
    localparam logic [9:0] K28_5 = 10'b001111_1010;
    localparam logic [9:0] K28_7 = 10'b001111_1000;   // start of frame
    localparam logic [9:0] K28_3 = 10'b001111_0011;   // end of frame
    localparam logic [9:0] D3_1  = 10'b110001_1001;   // 8'h23
    localparam logic [9:0] D5_2  = 10'b101001_0101;   // 8'h45
    localparam logic [9:0] D6_4  = 10'b011001_1101;   // 8'h86
    localparam logic [9:0] D9_3  = 10'b100101_1100;   // 8'h69
    localparam logic [9:0] D10_5 = 10'b010101_1010;   // 8'hAA
    localparam logic [9:0] D11_6 = 10'b110100_0110;   // 8'hCB
    localparam logic [9:0] BAD   = 10'b111111_0000;   // no such 6b sub-block

    localparam logic [31:0] WORD0 = {`FE_RX_DATA_ID, 8'h23, 8'h45, 8'h86};
    localparam logic [31:0] WORD1 = {`FE_RX_DATA_ID, 8'h69, 8'hAA, 8'hCB};

    typedef struct packed {
        logic [2:0]  kind;
        logic [15:0] addr;    // register address or 10-bit code
        logic [7:0]  wval;    // write value or symbol repeat count
        logic [31:0] exp;
    } step_t;

    logic                  BUS_CLK;
    logic                  RST;
    logic                  rx_data;
    logic                  rx_bit_en;
    logic                  fifo_read;
    logic [15:0]           bus_add;
    logic [7:0]            bus_data_in;
    logic                  bus_wr;
    logic                  bus_rd;
    logic [7:0]            bus_data_out;
    logic                  rx_ready;
    logic                  rx_dec_err;
    logic                  rx_overflow_err;
    logic                  fifo_empty;
    logic                  fifo_full;
    fe_rx_pkg::fifo_word_t fifo_data;

    step_t  steps [$];
    integer seed;
    integer errors;
    integer limit;
    logic   line_inv;     // mirrors the invert bit in the status byte

    fe_rx_core u_dut (
        .BUS_CLK         (BUS_CLK),
        .RST             (RST),
        .rx_data         (rx_data),
        .rx_bit_en       (rx_bit_en),
        .fifo_read       (fifo_read),
        .bus_add         (bus_add),
        .bus_data_in     (bus_data_in),
        .bus_wr          (bus_wr),
        .bus_rd          (bus_rd),
        .bus_data_out    (bus_data_out),
        .rx_ready        (rx_ready),
        .rx_dec_err      (rx_dec_err),
        .rx_overflow_err (rx_overflow_err),
        .fifo_empty      (fifo_empty),
        .fifo_full       (fifo_full),
        .fifo_data       (fifo_data)
    );

    initial BUS_CLK = 1'b0;
    always #5 BUS_CLK = ~BUS_CLK;

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s actual=%h expected=%h", $time, name, act, exp);
        end
    endtask

    task automatic add_step(input logic [2:0] kind, input logic [15:0] addr,
                            input logic [7:0] wval, input logic [31:0] exp);
        steps.push_back({kind, addr, wval, exp});
    endtask

    // SOF, six data bytes, EOF, then fill count and both words
    task automatic add_frame();
        add_step(K_SYM, K28_7, 1, 0);
        add_step(K_SYM, D3_1, 1, 0);
        add_step(K_SYM, D5_2, 1, 0);
        add_step(K_SYM, D6_4, 1, 0);
        add_step(K_SYM, D9_3, 1, 0);
        add_step(K_SYM, D10_5, 1, 0);
        add_step(K_SYM, D11_6, 1, 0);
        add_step(K_SYM, K28_3, 1, 0);
        add_step(K_RD, 3, 0, 8'd2);
        add_step(K_RD, 4, 0, 8'd0);
        add_step(K_POP, 0, 0, WORD0);
        add_step(K_POP, 0, 0, WORD1);
        add_step(K_FLG, 0, 0, 5'b10010);
    endtask

    // flags are {ready, dec_err, overflow_err, empty, full}
    task automatic build_table();
        add_step(K_RD, 0, 0, `FE_RX_VERSION);
        add_step(K_RD, 2, 0, 8'h00);
        add_step(K_FLG, 0, 0, 5'b00010);
        add_step(K_SYM, K28_5, 6, 0);
        add_step(K_FLG, 0, 0, 5'b10010);
        add_step(K_RD, 2, 0, 8'h01);
        add_frame();
        add_step(K_WR, 2, 8'h02, 0);      // line inverted from here
        add_step(K_WR, 1, 8'h00, 0);
        add_step(K_RD, 2, 0, 8'h02);
        add_step(K_SYM, K28_5, 6, 0);
        add_step(K_RD, 2, 0, 8'h03);
        add_frame();
        add_step(K_SYM, K28_7, 1, 0);
        add_step(K_SYM, BAD, 1, 0);
        add_step(K_SYM, D3_1, 1, 0);
        add_step(K_SYM, BAD, 1, 0);
        add_step(K_SYM, K28_3, 1, 0);
        add_step(K_FLG, 0, 0, 5'b11010);
        add_step(K_RD, 5, 0, 8'd2);
        add_step(K_SYM, K28_7, 1, 0);
        add_step(K_SYM, D3_1, 30, 0);     // ten words into an eight word fifo
        add_step(K_SYM, K28_3, 1, 0);
        add_step(K_FLG, 0, 0, 5'b11101);
        add_step(K_RD, 6, 0, 8'd2);
        add_step(K_RD, 3, 0, 8'd8);
        add_step(K_WR, 0, 8'h00, 0);
        add_step(K_RD, 2, 0, 8'h00);
        add_step(K_RD, 3, 0, 8'h00);
        add_step(K_RD, 5, 0, 8'h00);
        add_step(K_RD, 6, 0, 8'h00);
        add_step(K_FLG, 0, 0, 5'b00010);
    endtask

    task automatic send_symbol(input logic [9:0] code);
        integer i;
        for (i = 9; i >= 0; i--) begin
            if (($random(seed) & 3) == 0) begin
                @(posedge BUS_CLK);
                rx_bit_en <= 1'b0;    // idle strobe gap
            end
            @(posedge BUS_CLK);
            rx_data   <= code[i] ^ line_inv;
            rx_bit_en <= 1'b1;
        end
    endtask

    task automatic run_step(input step_t s);
        case (s.kind)
            K_WR: begin
                @(posedge BUS_CLK);
                bus_add     <= s.addr;
                bus_data_in <= s.wval;
                bus_wr      <= 1'b1;
                @(posedge BUS_CLK);
                bus_wr <= 1'b0;
                @(posedge BUS_CLK);   // internal reset pulse lands here
                if (s.addr == 16'd2)
                    line_inv = s.wval[1];
                else if (s.addr == 16'd0)
                    line_inv = 1'b0;
            end
            K_RD: begin
                @(posedge BUS_CLK);
                bus_add <= s.addr;
                bus_rd  <= 1'b1;
                @(posedge BUS_CLK);
                bus_rd <= 1'b0;
                @(negedge BUS_CLK);
                check_value($sformatf("bus_data_out[%0d]", s.addr), bus_data_out, s.exp);
            end
            K_SYM: begin
                repeat (s.wval) send_symbol(s.addr[9:0]);
                @(posedge BUS_CLK);
                rx_bit_en <= 1'b0;
                repeat (4) @(posedge BUS_CLK);    // aligner, decoder, packer, fifo
            end
            K_POP: begin
                @(negedge BUS_CLK);
                check_value("fifo_empty", fifo_empty, 32'd0);
                check_value("fifo_data", fifo_data, s.exp);
                @(posedge BUS_CLK);
                fifo_read <= 1'b1;
                @(posedge BUS_CLK);
                fifo_read <= 1'b0;
            end
            default: begin
                @(negedge BUS_CLK);
                check_value("rx_ready,rx_dec_err,rx_overflow_err,fifo_empty,fifo_full",
                            {rx_ready, rx_dec_err, rx_overflow_err, fifo_empty, fifo_full},
                            s.exp);
            end
        endcase
    endtask

    // watchdog, every symbol and every other step gets 40 cycles
    initial begin
        #1;
        limit = 8;
        foreach (steps[i])
            limit += (steps[i].kind == K_SYM) ? 40 * steps[i].wval : 40;
        repeat (limit) @(posedge BUS_CLK);
        $display("timeout after %0d cycles, the test sequence did not finish", limit);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        seed        = 55299;
        errors      = 0;
        line_inv    = 1'b0;
        RST         = 1'b1;
        rx_data     = 1'b0;
        rx_bit_en   = 1'b0;
        fifo_read   = 1'b0;
        bus_add     = 16'd0;
        bus_data_in = 8'd0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        build_table();
        repeat (8) @(posedge BUS_CLK);
        RST <= 1'b0;
        foreach (steps[i])
            run_step(steps[i]);
        repeat (4) @(posedge BUS_CLK);
        $display("checks done over %0d steps, %0d errors", steps.size(), errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
hdl/fe_rx_pkg.sv
hdl/rx_symbol_align.sv
hdl/dec_8b10b.sv
hdl/frame_packer.sv
hdl/word_fifo.sv
hdl/fe_rx_core.sv
tests/tb_fe_rx_core.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --timing --timescale 1ns/100ps -f tb.f \
    --top-module tb_fe_rx_core -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
